/* bench/esp_link_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module esp_link_properties #(
  parameter bit WATCH_DECODER = 1'b1
) (
  input logic clk,
  input logic cass_out_sel_n,
  input logic byte_valid,
  input logic trigger,
  input logic cmd_error
);

  // Byte strobe is a single clock wide
  a_valid_single: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    byte_valid |=> !byte_valid)
    else $error("byte_valid stayed high for two clocks");

  generate
    if (WATCH_DECODER) begin : g_decoder
      a_trigger_single: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
        trigger |=> !trigger)
        else $error("trigger stayed high for two clocks");

      // Trigger only ever follows the strobe of the frame's last byte
      a_trigger_after_valid: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
        trigger |-> $past(byte_valid))
        else $error("trigger rose without byte_valid one clock before");

      a_error_sticky: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
        !$fell(cmd_error))
        else $error("cmd_error cleared while out of reset");
    end
  endgenerate

endmodule

bind spi_byte_link esp_link_properties #(.WATCH_DECODER(1'b0)) u_link_props (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .byte_valid     (byte_valid),
  .trigger        (1'b0),
  .cmd_error      (1'b0)
);

bind cmd_decoder esp_link_properties #(.WATCH_DECODER(1'b1)) u_decoder_props (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .byte_valid     (byte_valid),
  .trigger        (cmd_bus.trigger),
  .cmd_error      (cmd_error)
);

`default_nettype wire

/* bench/esp_link_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module esp_link_tb;

  // About twice the length of all directed tests
  localparam int CYCLE_LIMIT = 6000;

  logic        clk = 1'b0;
  logic        cass_out_sel_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  wire         miso;
  logic        led_red;
  logic        led_green;
  logic        led_blue;
  logic [7:0]  esp_status;
  logic [23:0] screen_color;
  logic        key_pressed;
  logic        cmd_error;
  int          error_count = 0;
  int          cycle_count = 0;
  int          seed = 35;
  logic [2:0]  led_expected = 3'b000;

  esp_link_top uut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .key_pressed    (key_pressed),
    .cmd_error      (cmd_error)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic check_value(input string test_name, input logic [23:0] expected,
                             input logic [23:0] actual);
    if (actual !== expected) begin
      $display("ERROR: %s expected %h actual %h", test_name, expected, actual);
      error_count++;
    end
  endtask

  // SPI master, mode 0, msb first, each SCK phase 8 clk
  task automatic send_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] rx_shift;
    rx_shift = 8'h00;
    @(posedge clk);
    cs_n <= 1'b0;
    mosi <= tx[7];
    wait_clocks(8);
    for (int i = 7; i >= 0; i--) begin
      sck <= 1'b1;
      wait_clocks(8);
      sck <= 1'b0;
      if (i > 0)
        mosi <= tx[i-1];
      wait_clocks(7);
      // MISO has long settled by the end of the low phase
      @(negedge clk);
      rx_shift[i] = miso;
      @(posedge clk);
    end
    cs_n <= 1'b1;
    mosi <= 1'b0;
    wait_clocks(8);
    rx = rx_shift;
  endtask

  task automatic test_reset_values();
    check_value("reset leds", 24'd0, {led_blue, led_green, led_red});
    check_value("reset esp_status", 24'd0, esp_status);
    check_value("reset key_pressed", 24'd0, key_pressed);
    check_value("reset cmd_error", 24'd0, cmd_error);
    check_value("reset screen_color", 24'hFFFFFF, screen_color);
  endtask

  // Reply to a query comes back during the following byte
  task automatic test_query_replies();
    logic [7:0] rx;
    send_byte(8'd0, rx);
    send_byte(8'd0, rx);
    check_value("get_cookie reply", 24'hAF, rx);
    send_byte(8'd15, rx);
    send_byte(8'd0, rx);
    check_value("get_version reply", 24'h03, rx);
  endtask

  task automatic test_led_and_status();
    logic [7:0] rx;
    logic [7:0] p;
    p = $random(seed);
    // Zero would look like the reset state
    if (p[2:0] == 3'b000)
      p[2:0] = 3'b101;
    led_expected = p[2:0];
    send_byte(8'd26, rx);
    send_byte(p, rx);
    check_value("set_led red", p[0], led_red);
    check_value("set_led green", p[1], led_green);
    check_value("set_led blue", p[2], led_blue);
    p = $random(seed);
    if (p == 8'h00)
      p = 8'hA5;
    send_byte(8'd32, rx);
    send_byte(p, rx);
    check_value("set_esp_status", p, esp_status);
  endtask

  task automatic test_screen_color();
    logic [7:0] rx;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    red   = $random(seed);
    green = $random(seed);
    blue  = $random(seed);
    send_byte(8'd17, rx);
    send_byte(red, rx);
    send_byte(green, rx);
    send_byte(blue, rx);
    check_value("set_screen_color", {red, green, blue}, screen_color);
  endtask

  task automatic test_keyboard();
    logic [7:0] rx;
    logic [7:0] row_value;
    row_value = $random(seed);
    if (row_value == 8'h00)
      row_value = 8'h5A;
    send_byte(8'd19, rx);
    send_byte(8'd5, rx);
    send_byte(row_value, rx);
    check_value("send_keyb press", 24'd1, key_pressed);
    send_byte(8'd19, rx);
    send_byte(8'd5, rx);
    send_byte(8'd0, rx);
    check_value("send_keyb release", 24'd0, key_pressed);
  endtask

  task automatic test_unknown_command();
    logic [7:0] rx;
    logic [7:0] p;
    send_byte(8'd3, rx);
    check_value("unknown code error", 24'd1, cmd_error);
    // Parser must be back in idle for this frame to land
    p = $random(seed);
    // A new LED pattern, so a lost frame shows up
    if (p[2:0] == led_expected)
      p[2:0] = ~p[2:0];
    led_expected = p[2:0];
    send_byte(8'd26, rx);
    send_byte(p, rx);
    check_value("set_led after error", p[2:0], {led_blue, led_green, led_red});
    check_value("error stays set", 24'd1, cmd_error);
  endtask

  initial begin
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    cs_n           = 1'b1;
    mosi           = 1'b0;
    wait_clocks(16);
    cass_out_sel_n <= 1'b1;
    wait_clocks(2);
    test_reset_values();
    test_query_replies();
    test_led_and_status();
    test_screen_color();
    test_keyboard();
    test_unknown_command();
    $display("Run complete with %0d errors", error_count);
    if (error_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
verilog/esp_link_pkg.sv
verilog/cmd_if.sv
verilog/spi_byte_link.sv
verilog/cmd_decoder.sv
verilog/cmd_execute.sv
verilog/reply_register.sv
verilog/esp_link_top.sv
bench/esp_link_properties.sv
bench/esp_link_tb.sv

/* verilog/cmd_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  input  esp_link_pkg::byte_t byte_in,
  input  logic                byte_valid,
  output logic                cmd_error,
  cmd_if.decoder              cmd_bus
);
  import esp_link_pkg::*;

  parse_state_t state;
  param_cnt_t   remaining;
  param_cnt_t   slot;
  byte_t        pend_cmd;
  byte_t        param_store [0:1];
  logic         cmd_byte;
  logic         short_cmd;
  logic         last_param;

  assign cmd_byte   = byte_valid && (state == parse_idle);
  // Known command with nothing to wait for
  assign short_cmd  = cmd_byte && cmd_known(byte_in) && (cmd_param_count(byte_in) == 2'd0);
  assign last_param = byte_valid && (state == parse_params) && (remaining == 2'd1);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state           <= parse_idle;
      remaining       <= 2'd0;
      slot            <= 2'd0;
      cmd_error       <= 1'b0;
      cmd_bus.trigger <= 1'b0;
    end else begin
      cmd_bus.trigger <= short_cmd || last_param;
      if (byte_valid) begin
        case (state)
          parse_idle: begin
            slot <= 2'd0;
            if (!cmd_known(byte_in)) begin
              cmd_error <= 1'b1;
            end else if (cmd_param_count(byte_in) != 2'd0) begin
              remaining <= cmd_param_count(byte_in);
              state     <= parse_params;
            end
          end
          parse_params: begin
            slot <= slot + 2'd1;
            if (remaining == 2'd1)
              state <= parse_idle;
            else
              remaining <= remaining - 2'd1;
          end
          default: state <= parse_idle;
        endcase
      end
    end
  end

  // Parameters collect here and are published together with trigger
  always_ff @(posedge clk) begin
    if (cmd_byte)
      pend_cmd <= byte_in;
    if (byte_valid && (state == parse_params) && !slot[1])
      param_store[slot[0]] <= byte_in;

    if (short_cmd)
      cmd_bus.cmd <= byte_in;

    if (last_param) begin
      cmd_bus.cmd    <= pend_cmd;
      cmd_bus.param0 <= (slot == 2'd0) ? byte_in : param_store[0];
      cmd_bus.param1 <= (slot == 2'd1) ? byte_in : param_store[1];
      cmd_bus.param2 <= byte_in;
    end
  end

endmodule

`default_nettype wire

/* verilog/cmd_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_execute (
  input  logic                 clk,
  input  logic                 cass_out_sel_n,
  cmd_if.executor              cmd_bus,
  output esp_link_pkg::led_t   led,
  output esp_link_pkg::byte_t  esp_status,
  output esp_link_pkg::color_t screen_color,
  output logic                 key_pressed
);
  import esp_link_pkg::*;

  byte_t    keyb_rows [KEYB_ROWS];
  row_idx_t row_sel;
  logic     any_key;

  assign row_sel = cmd_bus.param0[2:0];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led          <= 3'b000;
      esp_status   <= 8'h00;
      screen_color <= 24'hFFFFFF;
      for (int i = 0; i < KEYB_ROWS; i++)
        keyb_rows[i] <= 8'h00;
    end else if (cmd_bus.trigger) begin
      case (cmd_bus.cmd)
        cmd_set_led:          led <= cmd_bus.param0[2:0];
        cmd_set_esp_status:   esp_status <= cmd_bus.param0;
        // Red comes first on the wire
        cmd_set_screen_color: screen_color <= {cmd_bus.param0, cmd_bus.param1, cmd_bus.param2};
        cmd_send_keyb:        keyb_rows[row_sel] <= cmd_bus.param1;
        default: ;
      endcase
    end
  end

  // Any key down anywhere in the matrix
  always_comb begin
    any_key = 1'b0;
    for (int i = 0; i < KEYB_ROWS; i++)
      any_key = any_key | (|keyb_rows[i]);
  end

  assign key_pressed = any_key;

endmodule

`default_nettype wire

/* verilog/cmd_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface cmd_if;
  import esp_link_pkg::*;

  // One-clock strobe, the fields hold until the next one
  logic  trigger;
  byte_t cmd;
  byte_t param0;
  byte_t param1;
  byte_t param2;

  modport decoder (output trigger, cmd, param0, param1, param2);
  modport executor (input trigger, cmd, param0, param1, param2);
  modport responder (input trigger, cmd);

endinterface

`default_nettype wire

/* verilog/esp_link_pkg.sv */
`default_nettype none

package esp_link_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] color_t;
  // Blue, green, red from bit 2 down
  typedef logic [2:0]  led_t;
  typedef logic [2:0]  row_idx_t;
  typedef logic [1:0]  param_cnt_t;

  typedef enum logic {
    parse_idle,
    parse_params
  } parse_state_t;

  // Command codes sent by the coprocessor
  localparam byte_t cmd_get_cookie       = 8'd0;
  localparam byte_t cmd_get_version      = 8'd15;
  localparam byte_t cmd_set_screen_color = 8'd17;
  localparam byte_t cmd_send_keyb        = 8'd19;
  localparam byte_t cmd_set_led          = 8'd26;
  localparam byte_t cmd_set_esp_status   = 8'd32;

  localparam int KEYB_ROWS = 8;

  function automatic logic cmd_known(input byte_t code);
    case (code)
      cmd_get_cookie, cmd_get_version, cmd_set_screen_color,
      cmd_send_keyb, cmd_set_led, cmd_set_esp_status: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Parameter bytes that follow each command byte
  function automatic param_cnt_t cmd_param_count(input byte_t code);
    case (code)
      cmd_set_screen_color: return 2'd3;
      cmd_send_keyb:        return 2'd2;
      cmd_set_led:          return 2'd1;
      cmd_set_esp_status:   return 2'd1;
      default:              return 2'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* verilog/esp_link_top.sv */
`timescale 1ns/10ps
`default_nettype none

module esp_link_top #(
  parameter esp_link_pkg::byte_t COOKIE        = 8'hAF,
  parameter logic [2:0]          VERSION_MAJOR = 3'd0,
  parameter logic [4:0]          VERSION_MINOR = 5'd3
) (
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  output logic        led_red,
  output logic        led_green,
  output logic        led_blue,
  output logic [7:0]  esp_status,
  output logic [23:0] screen_color,
  output logic        key_pressed,
  output logic        cmd_error
);
  import esp_link_pkg::*;

  byte_t byte_in;
  logic  byte_valid;
  byte_t reply_byte;
  led_t  led;

  cmd_if cmd_bus ();

  spi_byte_link u_link (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .byte_in        (byte_in),
    .byte_valid     (byte_valid),
    .reply_byte     (reply_byte)
  );

  cmd_decoder u_decoder (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .byte_in        (byte_in),
    .byte_valid     (byte_valid),
    .cmd_error      (cmd_error),
    .cmd_bus        (cmd_bus.decoder)
  );

  cmd_execute u_execute (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd_bus        (cmd_bus.executor),
    .led            (led),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .key_pressed    (key_pressed)
  );

  reply_register #(
    .COOKIE        (COOKIE),
    .VERSION_MAJOR (VERSION_MAJOR),
    .VERSION_MINOR (VERSION_MINOR)
  ) u_reply (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd_bus        (cmd_bus.responder),
    .reply_byte     (reply_byte)
  );

  assign led_red   = led[0];
  assign led_green = led[1];
  assign led_blue  = led[2];

endmodule

`default_nettype wire

/* verilog/reply_register.sv */
`timescale 1ns/10ps
`default_nettype none

module reply_register #(
  parameter esp_link_pkg::byte_t COOKIE        = 8'hAF,
  parameter logic [2:0]          VERSION_MAJOR = 3'd0,
  parameter logic [4:0]          VERSION_MINOR = 5'd3
) (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  cmd_if.responder            cmd_bus,
  output esp_link_pkg::byte_t reply_byte
);
  import esp_link_pkg::*;

  // Only the queries touch the reply, the rest leave it alone
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      reply_byte <= 8'h00;
    end else if (cmd_bus.trigger) begin
      case (cmd_bus.cmd)
        cmd_get_cookie:  reply_byte <= COOKIE;
        cmd_get_version: reply_byte <= {VERSION_MAJOR, VERSION_MINOR};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/spi_byte_link.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_byte_link (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  input  logic                sck,
  input  logic                cs_n,
  input  logic                mosi,
  output logic                miso,
  output esp_link_pkg::byte_t byte_in,
  output logic                byte_valid,
  input  esp_link_pkg::byte_t reply_byte
);

  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic       mosi_bit;
  logic [2:0] bit_cnt;
  logic [7:0] send_reg;

  // Pin synchronizers, idle levels under reset
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 3'b111;
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[2];
  assign mosi_bit  = mosi_sync[1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
      send_reg   <= 8'h00;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            byte_valid <= 1'b1;
        end
        // First falling edge of a byte picks up the pending reply
        if (sck_fall) begin
          if (bit_cnt == 3'd1)
            send_reg <= reply_byte;
          else
            send_reg <= {send_reg[6:0], 1'b0};
        end
      end
    end
  end

  // Receive shifter, msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      byte_in <= {byte_in[6:0], mosi_bit};
  end

  assign miso = cs_active ? send_reg[7] : 1'bz;

endmodule

`default_nettype wire
